/* core.f */
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/memory_writeback.sv
verilog/core.sv
verification/core_assertions.sv
verification/core_checker.sv
verification/core_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f core.f --top-module core_tb -o core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0

/* verification/core_stim.txt */
// @00 program words, @40 initial data words (byte address 0x00 up)
// @60 program word count and store count, @62 expected stores as (address data) pairs
@00
00600093 FFD00113 002081B3 04302023
40208233 04402223 0020F2B3 04502423
0020E333 04602623 0020C3B3 04702823
00112433 04802A23 002094B3 04902C23
00115533 04A02E23 06408593 06B02023
0F017613 06C02223 1000E693 06D02423
FFF0C713 06E02623 00012793 06F02823
12345837 07002A23 00002883 00188933
07202C23 00108463 0E102823 00209463
0E102823 008009EF 0E102823 07302E23
0B000A93 000A8A67 0E102823 0E102823
09402023 0000006F
@40
0BADF00D 11110004 22220008 3333000C
44440010 55550014 66660018 7777001C
88880020 99990024 AAAA0028 BBBB002C
CCCC0030 DDDD0034 EEEE0038 FFFF003C
@60
0000002E 00000011
@62
00000040 00000003 00000044 00000009
00000048 00000004 0000004C FFFFFFFF
00000050 FFFFFFFB 00000054 00000001
00000058 C0000000 0000005C 03FFFFFF
00000060 0000006A 00000064 000000F0
00000068 00000106 0000006C FFFFFFF9
00000070 00000001 00000074 12345000
00000078 0BADF013 0000007C 00000098
00000080 000000A8

/* verification/core_tb.sv */
`timescale 1ns/1ps

module core_tb import core_pkg::*;
();
	localparam word_t reset_vector = 32'h0;

	logic  clk, reset_n, stall, req, we, done, random_stall, timed_out;
	word_t instr, instr_addr, data_rd, data_addr, data_wr;
	word_t stim [0:255];
	word_t imem [0:63];
	word_t dmem [0:255];
	word_t exp_addr [0:31];
	word_t exp_data [0:31];
	int    prog_words, store_count, cycles, limit;
	int    seen, chk_checks, chk_errors;

	core #(.reset_vector(reset_vector)) dut (.clk_i(clk), .reset_i(reset_n), .instr_i(instr),
		.instr_addr_o(instr_addr), .data_i(data_rd), .data_stall_i(stall), .data_req_o(req),
		.data_we_o(we), .data_addr_o(data_addr), .data_o(data_wr));

	core_checker #(.reset_vector(reset_vector)) chk (.clk_i(clk), .reset_i(reset_n),
		.instr_addr_i(instr_addr), .data_req_i(req), .data_we_i(we),
		.data_stall_i(stall), .data_addr_i(data_addr), .data_i(data_wr),
		.exp_addr_i(exp_addr), .exp_data_i(exp_data), .exp_count_i(store_count),
		.done_o(done), .seen_o(seen), .check_count_o(chk_checks), .error_count_o(chk_errors));

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// both memories answer one edge after they see a request
	task automatic step_cycle();
		word_t fetch_addr, acc_addr, acc_data;
		logic  accept, acc_we;
		@(negedge clk);
		fetch_addr = instr_addr;
		accept = req && !stall;
		acc_we = we;
		acc_addr = data_addr;
		acc_data = data_wr;
		@(posedge clk);
		#1;
		instr = imem[fetch_addr[7:2]];
		if (accept && acc_we)
			dmem[acc_addr[9:2]] = acc_data;
		else if (accept)
			data_rd = dmem[acc_addr[9:2]];
		stall = random_stall && ($urandom % 3 == 0);
		cycles++;
	endtask

	task automatic load_data_memory();
		for (int i = 0; i < 256; i++)
			dmem[i] = 32'hC0DE_0000 ^ (i << 2); // pattern follows the byte address
		for (int i = 0; i < 16; i++)
			dmem[i] = stim[8'h40 + i];
	endtask

	initial
	begin
		void'($urandom(12));
		reset_n = 1'b0;
		stall = 1'b0;
		instr = nop_instr;
		data_rd = '0;
		random_stall = 1'b0;
		timed_out = 1'b0;
		$readmemh("verification/core_stim.txt", stim);
		prog_words = stim[8'h60];
		store_count = stim[8'h61];
		for (int i = 0; i < 64; i++)
			imem[i] = (i < prog_words) ? stim[i] : nop_instr;
		for (int i = 0; i < 32; i++)
		begin
			exp_addr[i] = (i < store_count) ? stim[8'h62 + 2 * i] : '0;
			exp_data[i] = (i < store_count) ? stim[8'h63 + 2 * i] : '0;
		end
		limit = 30 * prog_words + 200;

		// second pass adds random data stalls
		for (int pass = 0; pass < 2; pass++)
		begin
			reset_n = 1'b0;
			random_stall = 1'b0;
			stall = 1'b0;
			load_data_memory();
			repeat (16) step_cycle();
			reset_n = 1'b1;
			random_stall = (pass == 1);
			cycles = 0;
			while (!done && cycles < limit)
				step_cycle();
			if (!done)
			begin
				timed_out = 1'b1;
				$display("timeout after %0d cycles in pass %0d, missing stores: saw %0d of %0d",
					cycles, pass, seen, store_count);
				break;
			end
			repeat (20) step_cycle(); // catch late extra stores
		end

		$display("stores checked %0d, errors %0d", chk_checks, chk_errors);
		if (timed_out || chk_errors != 0)
			$display("tests failed");
		else
			$display("all tests passed");
		$finish;
	end

endmodule

/* verification/core_checker.sv */
`timescale 1ns/1ps

module core_checker import core_pkg::*;
#(
	parameter word_t reset_vector = 32'h0
)
(
	input  logic  clk_i,
	input  logic  reset_i,
	input  word_t instr_addr_i,
	input  logic  data_req_i,
	input  logic  data_we_i,
	input  logic  data_stall_i,
	input  word_t data_addr_i,
	input  word_t data_i,
	input  word_t exp_addr_i [0:31],
	input  word_t exp_data_i [0:31],
	input  int    exp_count_i,
	output logic  done_o,
	output int    seen_o,
	output int    check_count_o,
	output int    error_count_o
);
	int   index = 0;  // next expected store
	int   checks = 0;
	int   errors = 0;
	logic after_reset = 1'b0; // first fetch not yet checked

	// outputs are settled by the falling edge
	always @(negedge clk_i)
	begin
		if (!reset_i)
		begin
			index = 0;
			after_reset = 1'b1;
		end
		else
		begin
			if (after_reset && instr_addr_i !== reset_vector)
			begin
				errors++;
				$display("[ERROR] %0t: first fetch address %h, expected %h", $time,
					instr_addr_i, reset_vector);
			end
			after_reset = 1'b0;
			if (data_req_i && !data_stall_i)
			begin
				if (data_we_i && index >= exp_count_i)
				begin
					errors++;
					$display("extra store of %h to %h at %0t, no more stores were expected",
						data_i, data_addr_i, $time);
				end
				else if (data_we_i)
				begin
					checks++;
					if (data_addr_i !== exp_addr_i[index] || data_i !== exp_data_i[index])
					begin
						errors++;
						$display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
							$time, index, data_i, data_addr_i, exp_data_i[index],
							exp_addr_i[index]);
					end
					index++;
				end
				else if (index == 0)
				begin
					errors++; // nothing may touch memory before the first store
					$display("load request to %h came before the first store", data_addr_i);
				end
			end
		end
	end

	assign done_o = reset_i && exp_count_i > 0 && index >= exp_count_i;
	assign seen_o = index;
	assign check_count_o = checks;
	assign error_count_o = errors;

endmodule

/* verification/core_assertions.sv */
`timescale 1ns/1ps

module core_assertions import core_pkg::*;
(
	input logic  clk_i,
	input logic  reset_i,
	input logic  data_req_i,
	input logic  data_we_i,
	input logic  data_stall_i,
	input word_t data_addr_i,
	input word_t data_i,
	input word_t instr_addr_i
);
	assert property (@(posedge clk_i) disable iff (!reset_i) data_we_i |-> data_req_i)
		else $error("store flag without a data request");

	// a held request must not change under it
	assert property (@(posedge clk_i) disable iff (!reset_i)
		(data_req_i && data_stall_i) |=> ($stable(data_addr_i) && $stable(data_i)))
		else $error("stalled data request changed address or data");

	assert property (@(posedge clk_i) instr_addr_i[1:0] == 2'b00)
		else $error("instruction address not word aligned");

	assert property (@(posedge clk_i) !reset_i |-> !data_req_i)
		else $error("data request during reset");

endmodule

bind core core_assertions asrt (.clk_i(clk_i), .reset_i(reset_i), .data_req_i(data_req_o),
	.data_we_i(data_we_o), .data_stall_i(data_stall_i), .data_addr_i(data_addr_o),
	.data_i(data_o), .instr_addr_i(instr_addr_o));

/* verilog/core.sv */
`timescale 1ns/1ps

module core import core_pkg::*;
#(
	parameter word_t reset_vector = 32'h0
)
(
	input  logic  clk_i,
	input  logic  reset_i,
	input  word_t instr_i,
	output word_t instr_addr_o,
	input  word_t data_i,
	input  logic  data_stall_i, // freezes every pipeline register
	output logic  data_req_o,
	output logic  data_we_o,
	output word_t data_addr_o,
	output word_t data_o
);
	word_t     if_instr, if_pc;
	logic      hazard, take_branch;
	word_t     branch_target;
	reg_addr_t rs1_addr, rs2_addr;
	word_t     rs1_data, rs2_data;
	word_t     id_pc, id_imm, id_rs1_data, id_rs2_data;
	reg_addr_t id_rs1, id_rs2, id_rd;
	alu_op_t   id_alu_op;
	wb_sel_t   id_wb_sel;
	logic      id_use_imm, id_use_pc, id_reg_write, id_mem_read, id_mem_write;
	logic      id_branch, id_branch_ne, id_jump, id_jalr;
	reg_addr_t ex_rd;
	logic      ex_mem_read, ex_reg_write;
	word_t     ex_result, ex_link;
	wb_sel_t   ex_wb_sel;
	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	fetch_stage #(.reset_vector(reset_vector)) fetch (.clk_i(clk_i), .reset_i(reset_i),
		.stall_i(data_stall_i), .hazard_i(hazard), .take_branch_i(take_branch),
		.branch_target_i(branch_target), .instr_i(instr_i), .instr_addr_o(instr_addr_o),
		.if_instr_o(if_instr), .if_pc_o(if_pc));

	// hazard compares against the load now in EX, i.e. the ID/EX rd
	decode_stage decode (.clk_i(clk_i), .reset_i(reset_i), .stall_i(data_stall_i),
		.flush_i(take_branch), .if_instr_i(if_instr), .if_pc_i(if_pc),
		.rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .ex_rd_i(id_rd),
		.ex_mem_read_i(ex_mem_read), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
		.hazard_o(hazard), .id_pc_o(id_pc), .id_imm_o(id_imm), .id_rs1_o(id_rs1),
		.id_rs2_o(id_rs2), .id_rs1_data_o(id_rs1_data), .id_rs2_data_o(id_rs2_data),
		.id_rd_o(id_rd), .id_alu_op_o(id_alu_op), .id_wb_sel_o(id_wb_sel),
		.id_use_imm_o(id_use_imm), .id_use_pc_o(id_use_pc), .id_reg_write_o(id_reg_write),
		.id_mem_read_o(id_mem_read), .id_mem_write_o(id_mem_write), .id_branch_o(id_branch),
		.id_branch_ne_o(id_branch_ne), .id_jump_o(id_jump), .id_jalr_o(id_jalr));

	register_file regs (.clk_i(clk_i), .reset_i(reset_i), .rs1_addr_i(rs1_addr),
		.rs2_addr_i(rs2_addr), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
		.wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data));

	execute_stage execute (.clk_i(clk_i), .reset_i(reset_i), .stall_i(data_stall_i),
		.id_pc_i(id_pc), .id_imm_i(id_imm), .id_rs1_i(id_rs1), .id_rs2_i(id_rs2),
		.id_rs1_data_i(id_rs1_data), .id_rs2_data_i(id_rs2_data), .id_rd_i(id_rd),
		.id_alu_op_i(id_alu_op), .id_wb_sel_i(id_wb_sel), .id_use_imm_i(id_use_imm),
		.id_use_pc_i(id_use_pc), .id_reg_write_i(id_reg_write), .id_mem_read_i(id_mem_read),
		.id_mem_write_i(id_mem_write), .id_branch_i(id_branch), .id_branch_ne_i(id_branch_ne),
		.id_jump_i(id_jump), .id_jalr_i(id_jalr), .mem_rd_i(ex_rd),
		.mem_reg_write_i(ex_reg_write), .mem_result_i(ex_result), .wb_rd_i(wr_addr),
		.wb_reg_write_i(wr_en), .wb_data_i(wr_data), .take_branch_o(take_branch),
		.branch_target_o(branch_target), .data_req_o(data_req_o), .data_we_o(data_we_o),
		.data_addr_o(data_addr_o), .data_o(data_o), .ex_rd_o(ex_rd),
		.ex_mem_read_o(ex_mem_read), .ex_result_o(ex_result), .ex_reg_write_o(ex_reg_write),
		.ex_wb_sel_o(ex_wb_sel), .ex_link_o(ex_link));

	memory_writeback mem_wb (.clk_i(clk_i), .reset_i(reset_i), .stall_i(data_stall_i),
		.ex_result_i(ex_result), .ex_rd_i(ex_rd), .ex_reg_write_i(ex_reg_write),
		.ex_wb_sel_i(ex_wb_sel), .ex_link_i(ex_link), .data_i(data_i),
		.wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data));

endmodule

/* verilog/memory_writeback.sv */
`timescale 1ns/1ps

module memory_writeback import core_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	input  logic      stall_i,
	input  word_t     ex_result_i,
	input  reg_addr_t ex_rd_i,
	input  logic      ex_reg_write_i,
	input  wb_sel_t   ex_wb_sel_i,
	input  word_t     ex_link_i,
	input  word_t     data_i, // load data valid in the first MEM cycle
	output logic      wr_en_o,
	output reg_addr_t wr_addr_o,
	output word_t     wr_data_o
);
	logic    mem_fresh; // EX/MEM moved on at the last edge
	word_t   load_hold;
	word_t   wb_result, wb_load_data, wb_link_data;
	wb_sel_t wb_sel;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			mem_fresh <= 1'b0;
			wr_en_o <= 1'b0;
		end
		else
		begin
			mem_fresh <= !stall_i;
			if (!stall_i)
				wr_en_o <= ex_reg_write_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (mem_fresh)
			load_hold <= data_i; // keeps the load word over a stall
		if (!stall_i)
		begin
			wb_result <= ex_result_i;
			wb_load_data <= mem_fresh ? data_i : load_hold;
			wb_link_data <= ex_link_i;
			wb_sel <= ex_wb_sel_i;
			wr_addr_o <= ex_rd_i;
		end
	end

	always_comb
	begin
		case (wb_sel)
			wb_load: wr_data_o = wb_load_data;
			wb_link: wr_data_o = wb_link_data;
			default: wr_data_o = wb_result;
		endcase
	end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import core_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	input  logic      stall_i,
	input  word_t     id_pc_i,
	input  word_t     id_imm_i,
	input  reg_addr_t id_rs1_i,
	input  reg_addr_t id_rs2_i,
	input  word_t     id_rs1_data_i,
	input  word_t     id_rs2_data_i,
	input  reg_addr_t id_rd_i,
	input  alu_op_t   id_alu_op_i,
	input  wb_sel_t   id_wb_sel_i,
	input  logic      id_use_imm_i,
	input  logic      id_use_pc_i,
	input  logic      id_reg_write_i,
	input  logic      id_mem_read_i,
	input  logic      id_mem_write_i,
	input  logic      id_branch_i,
	input  logic      id_branch_ne_i,
	input  logic      id_jump_i,
	input  logic      id_jalr_i,
	input  reg_addr_t mem_rd_i,
	input  logic      mem_reg_write_i,
	input  word_t     mem_result_i,
	input  reg_addr_t wb_rd_i,
	input  logic      wb_reg_write_i,
	input  word_t     wb_data_i,
	output logic      take_branch_o,
	output word_t     branch_target_o,
	output logic      data_req_o,
	output logic      data_we_o,
	output word_t     data_addr_o,
	output word_t     data_o,
	output reg_addr_t ex_rd_o,
	output logic      ex_mem_read_o,
	output word_t     ex_result_o,
	output logic      ex_reg_write_o,
	output wb_sel_t   ex_wb_sel_o,
	output word_t     ex_link_o
);
	word_t rs1_fwd, rs2_fwd;
	word_t alu_b;
	word_t alu_result;
	word_t target_sum;

	// newest producer wins
	function automatic word_t forward(reg_addr_t rs, word_t reg_value);
		if (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == rs)
			return mem_result_i;
		else if (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == rs)
			return wb_data_i;
		return reg_value;
	endfunction

	always_comb
	begin
		rs1_fwd = forward(id_rs1_i, id_rs1_data_i);
		rs2_fwd = forward(id_rs2_i, id_rs2_data_i);
	end

	assign alu_b = id_use_imm_i ? id_imm_i : rs2_fwd;

	always_comb
	begin
		case (id_alu_op_i)
			alu_sub:    alu_result = rs1_fwd - alu_b;
			alu_and:    alu_result = rs1_fwd & alu_b;
			alu_or:     alu_result = rs1_fwd | alu_b;
			alu_xor:    alu_result = rs1_fwd ^ alu_b;
			alu_slt:    alu_result = {31'b0, $signed(rs1_fwd) < $signed(alu_b)};
			alu_sll:    alu_result = rs1_fwd << alu_b[4:0];
			alu_srl:    alu_result = rs1_fwd >> alu_b[4:0];
			alu_pass_b: alu_result = alu_b;
			default:    alu_result = rs1_fwd + alu_b;
		endcase
	end

	assign take_branch_o = id_jump_i || (id_branch_i && ((rs1_fwd == rs2_fwd) != id_branch_ne_i));
	assign target_sum = (id_use_pc_i ? id_pc_i : rs1_fwd) + id_imm_i;
	assign branch_target_o = {target_sum[31:1], target_sum[0] & ~id_jalr_i}; // jalr drops bit 0

	assign data_req_o = id_mem_read_i || id_mem_write_i;
	assign data_we_o = id_mem_write_i;
	assign data_addr_o = alu_result;
	assign data_o = rs2_fwd;
	assign ex_mem_read_o = id_mem_read_i && (id_rd_i != '0); // load result can be needed

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			ex_reg_write_o <= 1'b0;
		else if (!stall_i)
			ex_reg_write_o <= id_reg_write_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall_i)
		begin
			ex_result_o <= alu_result;
			ex_rd_o <= id_rd_i;
			ex_wb_sel_o <= id_wb_sel_i;
			ex_link_o <= id_pc_i + 32'd4;
		end
	end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps

module register_file import core_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	input  reg_addr_t rs1_addr_i,
	input  reg_addr_t rs2_addr_i,
	output word_t     rs1_data_o,
	output word_t     rs2_data_o,
	input  logic      wr_en_i,
	input  reg_addr_t wr_addr_i,
	input  word_t     wr_data_i
);
	word_t regs [31:1]; // x0 has no storage

	// falling edge write, decode reads the new value before the next rising edge
	always_ff @(negedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en_i && wr_addr_i != '0)
			regs[wr_addr_i] <= wr_data_i;
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import core_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	input  logic      stall_i,
	input  logic      flush_i,
	input  word_t     if_instr_i,
	input  word_t     if_pc_i,
	input  word_t     rs1_data_i,
	input  word_t     rs2_data_i,
	input  reg_addr_t ex_rd_i,
	input  logic      ex_mem_read_i,
	output reg_addr_t rs1_addr_o,
	output reg_addr_t rs2_addr_o,
	output logic      hazard_o,
	output word_t     id_pc_o,
	output word_t     id_imm_o,
	output reg_addr_t id_rs1_o,
	output reg_addr_t id_rs2_o,
	output word_t     id_rs1_data_o,
	output word_t     id_rs2_data_o,
	output reg_addr_t id_rd_o,
	output alu_op_t   id_alu_op_o,
	output wb_sel_t   id_wb_sel_o,
	output logic      id_use_imm_o,
	output logic      id_use_pc_o,
	output logic      id_reg_write_o,
	output logic      id_mem_read_o,
	output logic      id_mem_write_o,
	output logic      id_branch_o,
	output logic      id_branch_ne_o,
	output logic      id_jump_o,
	output logic      id_jalr_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t      imm;
	alu_op_t    funct_op;
	alu_op_t    alu_op;
	wb_sel_t    wb_sel;
	logic [8:0] ctrl;
	logic       use_rs1, use_rs2, use_imm, use_pc;
	logic       reg_write, mem_read, mem_write, branch, jump;
	logic       bubble;

	assign opcode = if_instr_i[6:0];
	assign funct3 = if_instr_i[14:12];
	assign rs1_addr_o = if_instr_i[19:15];
	assign rs2_addr_o = if_instr_i[24:20];

	assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
	assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
	assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
		if_instr_i[30:25], if_instr_i[11:8], 1'b0};
	assign imm_u = {if_instr_i[31:12], 12'b0};
	assign imm_j = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
		if_instr_i[20], if_instr_i[30:21], 1'b0};

	always_comb
	begin
		case (funct3)
			3'b000: funct_op = (opcode == opc_op && if_instr_i[30]) ? alu_sub : alu_add;
			3'b001: funct_op = alu_sll;
			3'b010: funct_op = alu_slt;
			3'b100: funct_op = alu_xor;
			3'b101: funct_op = alu_srl;
			3'b110: funct_op = alu_or;
			default: funct_op = alu_and;
		endcase
		// sources and operand selects | reg_write, mem_read, mem_write, branch, jump
		case (opcode)
			opc_op:     ctrl = 9'b1100_10000;
			opc_op_imm: ctrl = 9'b1010_10000;
			opc_lui:    ctrl = 9'b0010_10000;
			opc_load:   ctrl = 9'b1010_11000;
			opc_store:  ctrl = 9'b1110_00100;
			opc_branch: ctrl = 9'b1111_00010;
			opc_jal:    ctrl = 9'b0001_10001;
			opc_jalr:   ctrl = 9'b1010_10001;
			default:    ctrl = '0; // unsupported, runs as a nop
		endcase
		case (opcode)
			opc_lui:    imm = imm_u;
			opc_store:  imm = imm_s;
			opc_branch: imm = imm_b;
			opc_jal:    imm = imm_j;
			default:    imm = imm_i;
		endcase
	end

	assign {use_rs1, use_rs2, use_imm, use_pc, reg_write, mem_read, mem_write, branch, jump} = ctrl;
	assign alu_op = (opcode == opc_lui) ? alu_pass_b :
		(opcode == opc_op || opcode == opc_op_imm) ? funct_op : alu_add;
	assign wb_sel = (opcode == opc_load) ? wb_load : (jump ? wb_link : wb_alu);

	// load in EX feeding a source read here
	assign hazard_o = ex_mem_read_i &&
		((use_rs1 && rs1_addr_o != '0 && rs1_addr_o == ex_rd_i) ||
		(use_rs2 && rs2_addr_o != '0 && rs2_addr_o == ex_rd_i));
	assign bubble = flush_i || hazard_o;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			{id_reg_write_o, id_mem_read_o, id_mem_write_o, id_branch_o, id_jump_o} <= '0;
		else if (!stall_i)
			{id_reg_write_o, id_mem_read_o, id_mem_write_o, id_branch_o, id_jump_o} <=
				bubble ? 5'b0 : {reg_write, mem_read, mem_write, branch, jump};
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall_i)
		begin
			id_pc_o <= if_pc_i;
			id_imm_o <= imm;
			id_rs1_o <= rs1_addr_o;
			id_rs2_o <= rs2_addr_o;
			id_rs1_data_o <= rs1_data_i;
			id_rs2_data_o <= rs2_data_i;
			id_rd_o <= if_instr_i[11:7];
			id_alu_op_o <= alu_op;
			id_wb_sel_o <= wb_sel;
			id_use_imm_o <= use_imm;
			id_use_pc_o <= use_pc; // pc relative target
			id_branch_ne_o <= funct3[0];
			id_jalr_o <= (opcode == opc_jalr);
		end
	end

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import core_pkg::*;
#(
	parameter word_t reset_vector = 32'h0
)
(
	input  logic  clk_i,
	input  logic  reset_i,
	input  logic  stall_i,
	input  logic  hazard_i,
	input  logic  take_branch_i,
	input  word_t branch_target_i,
	input  word_t instr_i,
	output word_t instr_addr_o, // next pc, seen by the memory on the coming edge
	output word_t if_instr_o,
	output word_t if_pc_o
);
	word_t pc_q;        // address of the word now on instr_i
	logic  fetch_valid; // cleared until the first real fetch

	always_comb
	begin
		if (stall_i)
			instr_addr_o = pc_q;
		else if (take_branch_i)
			instr_addr_o = branch_target_i;
		else if (hazard_i)
			instr_addr_o = pc_q; // refetch the same word
		else
			instr_addr_o = pc_q + 32'd4;
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q <= reset_vector - 32'd4; // next pc comes out as reset_vector
			fetch_valid <= 1'b0;
			if_instr_o <= nop_instr;
		end
		else if (!stall_i)
		begin
			pc_q <= instr_addr_o;
			fetch_valid <= 1'b1;
			if (take_branch_i)
				if_instr_o <= nop_instr; // flush
			else if (!hazard_i)
				if_instr_o <= fetch_valid ? instr_i : nop_instr;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall_i && !take_branch_i && !hazard_i)
			if_pc_o <= pc_q;
	end

endmodule

/* verilog/core_pkg.sv */
package core_pkg;

	typedef logic [31:0] word_t; // data, address and instruction words
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [3:0]
	{
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_pass_b // lui, operand b straight through
	} alu_op_t;

	// writeback source
	typedef enum logic [1:0]
	{
		wb_alu,
		wb_load,
		wb_link
	} wb_sel_t;

	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;

	localparam word_t nop_instr = 32'h0000_0013; // addi x0,x0,0

endpackage
